// File: design/dac_ctrl_pkg.sv
package dac_ctrl_pkg;

	// ******************************
	// Bus and frame widths
	// ******************************
	localparam int AXI_ID_W   = 4;
	localparam int AXI_DATA_W = 64;
	localparam int AXI_LEN_W  = 8;
	localparam int DAC_CODE_W = 10;
	localparam int FRAME_W    = 24;
	localparam int CMD_W      = 4;
	localparam int CH_W       = 4;
	localparam int PAD_W      = FRAME_W - CMD_W - CH_W - DAC_CODE_W;	// Low filler bits

	// Serial timing, in sys_clk and sclk units
	localparam int SCLK_DIV   = 5;	// sys_clk per sclk
	localparam int SCLK_HIGH  = 3;
	localparam int DIV_W      = $clog2(SCLK_DIV);
	localparam int TIME_RESET = 4;	// sclk periods
	localparam int TIME_SYNC  = 10;	// sclk periods
	localparam int CNT_W      = $clog2(FRAME_W + 1);

	// DAC command and channel codes
	localparam logic [CMD_W-1:0] CMD_WRITE = 4'd3;
	localparam logic [CMD_W-1:0] CMD_READ  = 4'd9;
	localparam logic [CH_W-1:0]  CH_ALL    = 4'd9;
	localparam logic [CH_W-1:0]  CH_A      = 4'd1;

	// Magic words from the host
	localparam logic [AXI_DATA_W-1:0] MOTOR_ENABLE   = 64'h0000_0000_0000_EAEA;
	localparam logic [AXI_DATA_W-1:0] MOTOR_POSITIVE = 64'h0000_0000_0000_1EAF;
	localparam logic [1:0]            BRESP_OKAY     = 2'b00;

	// One-hot bit positions of the write slave FSM
	localparam int AW_IDLE  = 0;
	localparam int AW_ADDR  = 1;
	localparam int AW_DATA  = 2;
	localparam int AW_RESP  = 3;
	localparam int AXI_ST_W = 4;

	// Engine and sequencer state codes
	localparam logic [1:0] ENG_RESET = 2'd0;
	localparam logic [1:0] ENG_IDLE  = 2'd1;
	localparam logic [1:0] ENG_GAP   = 2'd2;
	localparam logic [1:0] ENG_SHIFT = 2'd3;
	localparam logic [1:0] SEQ_IDLE  = 2'd0;
	localparam logic [1:0] SEQ_WRITE = 2'd1;
	localparam logic [1:0] SEQ_READ  = 2'd2;
	localparam logic [1:0] SEQ_NOP   = 2'd3;

	// ******************************
	// Serial frame, MSB first on the wire
	typedef union packed {
		logic [FRAME_W-1:0] raw;	// Shift and capture view
		struct packed {
			logic [CMD_W-1:0]      cmd;
			logic [CH_W-1:0]       ch;
			logic [DAC_CODE_W-1:0] code;
			logic [PAD_W-1:0]      pad;
		} fld;
	} dac_frame_u;

endpackage

// File: design/axi_write_slave.sv
`timescale 1ns/100ps

module axi_write_slave (
	input  logic                                sys_clk,
	input  logic                                sys_rst,
	input  logic [dac_ctrl_pkg::AXI_ID_W-1:0]   i_awid,
	input  logic [dac_ctrl_pkg::AXI_LEN_W-1:0]  i_awlen,
	input  logic                                i_awvalid,
	output logic                                o_awready,
	input  logic [dac_ctrl_pkg::AXI_DATA_W-1:0] i_wdata,
	input  logic                                i_wlast,
	input  logic                                i_wvalid,
	output logic                                o_wready,
	output logic [dac_ctrl_pkg::AXI_ID_W-1:0]   o_bid,
	output logic [1:0]                          o_bresp,
	output logic                                o_bvalid,
	input  logic                                i_bready,
	input  logic                                i_busy,	// DAC sequence running
	output logic                                o_beat_valid,
	output logic [dac_ctrl_pkg::AXI_LEN_W-1:0]  o_beat_idx,
	output logic [dac_ctrl_pkg::AXI_DATA_W-1:0] o_beat_data,
	output logic                                o_resp_done
);

	logic [dac_ctrl_pkg::AXI_ST_W-1:0]  state;
	logic [dac_ctrl_pkg::AXI_ST_W-1:0]  state_nxt;
	logic [dac_ctrl_pkg::AXI_ID_W-1:0]  id_q;
	logic [dac_ctrl_pkg::AXI_LEN_W-1:0] len_q;	// Beats minus one
	logic [dac_ctrl_pkg::AXI_LEN_W-1:0] beat_cnt;
	logic                               w_fire;
	logic                               w_end;

	assign w_fire = i_wvalid && o_wready;
	assign w_end  = w_fire && (i_wlast || beat_cnt == len_q);	// Length as a backstop to wlast

	// ******************************
	// One-hot FSM
	// ******************************
	always_comb begin
		state_nxt = '0;
		case (1'b1)
			state[dac_ctrl_pkg::AW_IDLE]: begin
				if (i_awvalid && !i_busy)
					state_nxt[dac_ctrl_pkg::AW_ADDR] = 1'b1;
				else
					state_nxt[dac_ctrl_pkg::AW_IDLE] = 1'b1;
			end
			state[dac_ctrl_pkg::AW_ADDR]: begin
				if (i_awvalid)	// Handshake this cycle
					state_nxt[dac_ctrl_pkg::AW_DATA] = 1'b1;
				else
					state_nxt[dac_ctrl_pkg::AW_IDLE] = 1'b1;
			end
			state[dac_ctrl_pkg::AW_DATA]: begin
				if (w_end)
					state_nxt[dac_ctrl_pkg::AW_RESP] = 1'b1;
				else
					state_nxt[dac_ctrl_pkg::AW_DATA] = 1'b1;
			end
			state[dac_ctrl_pkg::AW_RESP]: begin
				if (i_bready)
					state_nxt[dac_ctrl_pkg::AW_IDLE] = 1'b1;
				else
					state_nxt[dac_ctrl_pkg::AW_RESP] = 1'b1;
			end
			default: state_nxt[dac_ctrl_pkg::AW_IDLE] = 1'b1;	// Recover from a bad code
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state                        <= '0;
			state[dac_ctrl_pkg::AW_IDLE] <= 1'b1;
			o_wready                     <= 1'b0;
			beat_cnt                     <= '0;
		end else begin
			state    <= state_nxt;
			o_wready <= state_nxt[dac_ctrl_pkg::AW_DATA] && i_wvalid;	// Follows wvalid
			if (o_awready)
				beat_cnt <= '0;
			else if (w_fire)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// ID and length of the accepted burst
	always_ff @(posedge sys_clk) begin
		if (o_awready && i_awvalid) begin
			id_q  <= i_awid;
			len_q <= i_awlen;
		end
	end

	assign o_awready    = state[dac_ctrl_pkg::AW_ADDR];	// One-cycle pulse
	assign o_bvalid     = state[dac_ctrl_pkg::AW_RESP];
	assign o_bid        = id_q;
	assign o_bresp      = dac_ctrl_pkg::BRESP_OKAY;
	assign o_resp_done  = o_bvalid && i_bready;
	assign o_beat_valid = w_fire;
	assign o_beat_idx   = beat_cnt;
	assign o_beat_data  = i_wdata;

endmodule

// File: design/motor_cmd_decode.sv
`timescale 1ns/100ps

module motor_cmd_decode (
	input  logic                                sys_clk,
	input  logic                                sys_rst,
	input  logic                                i_beat_valid,
	input  logic [dac_ctrl_pkg::AXI_LEN_W-1:0]  i_beat_idx,
	input  logic [dac_ctrl_pkg::AXI_DATA_W-1:0] i_beat_data,
	input  logic                                i_resp_done,
	output logic                                o_motor_state,
	output logic                                o_motor_direction,
	output logic [dac_ctrl_pkg::DAC_CODE_W-1:0] o_code,
	output logic                                o_start
);

	// ******************************
	// Motor bits, beats 0 and 1
	// ******************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			o_motor_state     <= 1'b0;	// Stopped
			o_motor_direction <= 1'b1;	// Positive
			o_start           <= 1'b0;
		end else begin
			o_start <= i_resp_done;	// Kick the DAC once the host has its response
			if (i_beat_valid && i_beat_idx == dac_ctrl_pkg::AXI_LEN_W'(0))
				o_motor_state <= (i_beat_data == dac_ctrl_pkg::MOTOR_ENABLE);
			if (i_beat_valid && i_beat_idx == dac_ctrl_pkg::AXI_LEN_W'(1))
				o_motor_direction <= (i_beat_data == dac_ctrl_pkg::MOTOR_POSITIVE);
		end
	end

	// DAC code from beat 2, later beats ignored
	always_ff @(posedge sys_clk) begin
		if (i_beat_valid && i_beat_idx == dac_ctrl_pkg::AXI_LEN_W'(2))
			o_code <= i_beat_data[dac_ctrl_pkg::DAC_CODE_W-1:0];
	end

endmodule

// File: design/dac_serial_engine.sv
`timescale 1ns/100ps

module dac_serial_engine (
	input  logic                     sys_clk,
	input  logic                     sys_rst,
	input  logic                     i_send,
	input  dac_ctrl_pkg::dac_frame_u i_frame,
	output logic                     o_frame_done,
	output dac_ctrl_pkg::dac_frame_u o_rx_frame,
	output logic                     o_sclk,
	output logic                     o_sync_n,
	output logic                     o_sdin,
	output logic                     o_reset_n,
	output logic                     o_reset_busy,
	input  logic                     i_sdo
);

	logic [dac_ctrl_pkg::DIV_W-1:0] div_cnt;
	logic [dac_ctrl_pkg::DIV_W-1:0] div_nxt;
	logic                           rise_tick;	// sclk goes high at this edge
	logic                           fall_tick;	// sclk goes low at this edge
	logic [1:0]                     state;
	logic [dac_ctrl_pkg::CNT_W-1:0] cnt;	// Periods or bits, per state
	dac_ctrl_pkg::dac_frame_u       tx_q;
	dac_ctrl_pkg::dac_frame_u       rx_q;
	logic                           load;
	logic                           shift_out;
	logic                           capture;

	// ******************************
	// sclk divider
	// ******************************
	assign rise_tick = (div_cnt == dac_ctrl_pkg::DIV_W'(dac_ctrl_pkg::SCLK_DIV - 1));
	assign fall_tick = (div_cnt == dac_ctrl_pkg::DIV_W'(dac_ctrl_pkg::SCLK_HIGH - 1));
	assign div_nxt   = rise_tick ? '0 : div_cnt + 1'b1;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_cnt <= dac_ctrl_pkg::DIV_W'(dac_ctrl_pkg::SCLK_HIGH);	// Start in low phase
			o_sclk  <= 1'b0;
		end else begin
			div_cnt <= div_nxt;
			o_sclk  <= (div_nxt < dac_ctrl_pkg::DIV_W'(dac_ctrl_pkg::SCLK_HIGH));
		end
	end

	assign load      = (state == dac_ctrl_pkg::ENG_IDLE) && i_send;
	assign shift_out = rise_tick && (
		(state == dac_ctrl_pkg::ENG_GAP && cnt == dac_ctrl_pkg::CNT_W'(dac_ctrl_pkg::TIME_SYNC)) ||
		(state == dac_ctrl_pkg::ENG_SHIFT && cnt != dac_ctrl_pkg::CNT_W'(dac_ctrl_pkg::FRAME_W)));
	assign capture   = fall_tick && (state == dac_ctrl_pkg::ENG_SHIFT);

	// ******************************
	// Reset pulse and frame control
	// ******************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state        <= dac_ctrl_pkg::ENG_RESET;
			cnt          <= '0;
			o_reset_n    <= 1'b0;
			o_sync_n     <= 1'b1;
			o_sdin       <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			o_frame_done <= 1'b0;
			if (shift_out)
				o_sdin <= tx_q.raw[dac_ctrl_pkg::FRAME_W-1];	// MSB first, on sclk rise
			case (state)
				dac_ctrl_pkg::ENG_RESET: begin
					if (rise_tick)
						cnt <= cnt + 1'b1;
					else if (fall_tick && cnt == dac_ctrl_pkg::CNT_W'(dac_ctrl_pkg::TIME_RESET)) begin
						o_reset_n <= 1'b1;	// Release between edges
						cnt       <= '0;
						state     <= dac_ctrl_pkg::ENG_IDLE;
					end
				end
				dac_ctrl_pkg::ENG_IDLE: begin
					if (i_send) begin
						cnt   <= '0;
						state <= dac_ctrl_pkg::ENG_GAP;
					end
				end
				dac_ctrl_pkg::ENG_GAP: begin
					if (shift_out) begin	// Gap over, frame starts
						o_sync_n <= 1'b0;
						cnt      <= '0;
						state    <= dac_ctrl_pkg::ENG_SHIFT;
					end else if (rise_tick)
						cnt <= cnt + 1'b1;
				end
				default: begin	// ENG_SHIFT
					if (capture)
						cnt <= cnt + 1'b1;	// Bits seen by the DAC
					else if (rise_tick && cnt == dac_ctrl_pkg::CNT_W'(dac_ctrl_pkg::FRAME_W)) begin
						o_sync_n     <= 1'b1;
						o_sdin       <= 1'b0;
						o_frame_done <= 1'b1;
						state        <= dac_ctrl_pkg::ENG_IDLE;
					end
				end
			endcase
		end
	end

	// Shift registers
	always_ff @(posedge sys_clk) begin
		if (load)
			tx_q <= i_frame;
		else if (shift_out)
			tx_q.raw <= {tx_q.raw[dac_ctrl_pkg::FRAME_W-2:0], 1'b0};
		if (capture)
			rx_q.raw <= {rx_q.raw[dac_ctrl_pkg::FRAME_W-2:0], i_sdo};	// sdo on sclk fall
	end

	assign o_rx_frame   = rx_q;
	assign o_reset_busy = (state == dac_ctrl_pkg::ENG_RESET);

endmodule

// File: design/dac_sequencer.sv
`timescale 1ns/100ps

module dac_sequencer (
	input  logic                                sys_clk,
	input  logic                                sys_rst,
	input  logic                                i_start,
	input  logic [dac_ctrl_pkg::DAC_CODE_W-1:0] i_code,
	input  logic                                i_reset_busy,
	input  logic                                i_frame_done,
	input  dac_ctrl_pkg::dac_frame_u            i_rx_frame,
	output logic                                o_send,
	output dac_ctrl_pkg::dac_frame_u            o_frame,
	output logic                                o_dac_busy,
	output logic                                o_dac_ok
);

	logic [1:0]                          state;
	logic [dac_ctrl_pkg::DAC_CODE_W-1:0] code_q;	// Code written, for the check
	logic                                issue_wr;
	logic                                issue_rd;
	logic                                issue_nop;
	logic                                finish;

	// Build a frame from its fields
	function automatic dac_ctrl_pkg::dac_frame_u make_frame(
		input logic [dac_ctrl_pkg::CMD_W-1:0]      cmd,
		input logic [dac_ctrl_pkg::CH_W-1:0]       ch,
		input logic [dac_ctrl_pkg::DAC_CODE_W-1:0] code
	);
		dac_ctrl_pkg::dac_frame_u fr;
		fr.fld.cmd  = cmd;
		fr.fld.ch   = ch;
		fr.fld.code = code;
		fr.fld.pad  = '0;
		return fr;
	endfunction

	assign issue_wr  = (state == dac_ctrl_pkg::SEQ_IDLE) && i_start;
	assign issue_rd  = (state == dac_ctrl_pkg::SEQ_WRITE) && i_frame_done;
	assign issue_nop = (state == dac_ctrl_pkg::SEQ_READ) && i_frame_done;
	assign finish    = (state == dac_ctrl_pkg::SEQ_NOP) && i_frame_done;	// Readback captured

	// ******************************
	// Write, read, no-op
	// ******************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= dac_ctrl_pkg::SEQ_IDLE;
			o_send   <= 1'b0;
			o_dac_ok <= 1'b0;
		end else begin
			o_send <= issue_wr || issue_rd || issue_nop;
			if (issue_wr)
				state <= dac_ctrl_pkg::SEQ_WRITE;
			else if (issue_rd)
				state <= dac_ctrl_pkg::SEQ_READ;
			else if (issue_nop)
				state <= dac_ctrl_pkg::SEQ_NOP;
			else if (finish) begin
				state    <= dac_ctrl_pkg::SEQ_IDLE;
				o_dac_ok <= (i_rx_frame.fld.code == code_q);
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (issue_wr) begin
			code_q  <= i_code;
			o_frame <= make_frame(dac_ctrl_pkg::CMD_WRITE, dac_ctrl_pkg::CH_ALL, i_code);
		end else if (issue_rd)
			o_frame <= make_frame(dac_ctrl_pkg::CMD_READ, dac_ctrl_pkg::CH_A, '0);
		else if (issue_nop)
			o_frame.raw <= '0;
	end

	// Start counts as busy so no address slips in before state moves
	assign o_dac_busy = (state != dac_ctrl_pkg::SEQ_IDLE) || i_start || i_reset_busy;

endmodule

// File: design/dac_ctrl_top.sv
`timescale 1ns/100ps

module dac_ctrl_top (
	input  logic                                sys_clk,
	input  logic                                sys_rst,
	input  logic [dac_ctrl_pkg::AXI_ID_W-1:0]   i_awid,
	input  logic [dac_ctrl_pkg::AXI_LEN_W-1:0]  i_awlen,
	input  logic                                i_awvalid,
	output logic                                o_awready,
	input  logic [dac_ctrl_pkg::AXI_DATA_W-1:0] i_wdata,
	input  logic                                i_wlast,
	input  logic                                i_wvalid,
	output logic                                o_wready,
	output logic [dac_ctrl_pkg::AXI_ID_W-1:0]   o_bid,
	output logic [1:0]                          o_bresp,
	output logic                                o_bvalid,
	input  logic                                i_bready,
	output logic                                o_sclk,
	output logic                                o_sync_n,
	output logic                                o_sdin,
	output logic                                o_reset_n,
	input  logic                                i_sdo,
	output logic                                o_motor_state,
	output logic                                o_motor_direction,
	output logic                                o_dac_busy,
	output logic                                o_dac_ok
);

	// ******************************
	// Internal nets
	// ******************************
	logic                                beat_valid;
	logic [dac_ctrl_pkg::AXI_LEN_W-1:0]  beat_idx;
	logic [dac_ctrl_pkg::AXI_DATA_W-1:0] beat_data;
	logic                                resp_done;
	logic [dac_ctrl_pkg::DAC_CODE_W-1:0] code;
	logic                                start;
	logic                                send;
	dac_ctrl_pkg::dac_frame_u            frame;
	logic                                frame_done;
	dac_ctrl_pkg::dac_frame_u            rx_frame;
	logic                                reset_busy;

	axi_write_slave u_axi_write_slave (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.i_awid       (i_awid),
		.i_awlen      (i_awlen),
		.i_awvalid    (i_awvalid),
		.o_awready    (o_awready),
		.i_wdata      (i_wdata),
		.i_wlast      (i_wlast),
		.i_wvalid     (i_wvalid),
		.o_wready     (o_wready),
		.o_bid        (o_bid),
		.o_bresp      (o_bresp),
		.o_bvalid     (o_bvalid),
		.i_bready     (i_bready),
		.i_busy       (o_dac_busy),	// Holds off new bursts
		.o_beat_valid (beat_valid),
		.o_beat_idx   (beat_idx),
		.o_beat_data  (beat_data),
		.o_resp_done  (resp_done)
	);

	motor_cmd_decode u_motor_cmd_decode (
		.sys_clk           (sys_clk),
		.sys_rst           (sys_rst),
		.i_beat_valid      (beat_valid),
		.i_beat_idx        (beat_idx),
		.i_beat_data       (beat_data),
		.i_resp_done       (resp_done),
		.o_motor_state     (o_motor_state),
		.o_motor_direction (o_motor_direction),
		.o_code            (code),
		.o_start           (start)
	);

	dac_sequencer u_dac_sequencer (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.i_start      (start),
		.i_code       (code),
		.i_reset_busy (reset_busy),
		.i_frame_done (frame_done),
		.i_rx_frame   (rx_frame),
		.o_send       (send),
		.o_frame      (frame),
		.o_dac_busy   (o_dac_busy),
		.o_dac_ok     (o_dac_ok)
	);

	dac_serial_engine u_dac_serial_engine (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.i_send       (send),
		.i_frame      (frame),
		.o_frame_done (frame_done),
		.o_rx_frame   (rx_frame),
		.o_sclk       (o_sclk),
		.o_sync_n     (o_sync_n),
		.o_sdin       (o_sdin),
		.o_reset_n    (o_reset_n),
		.o_reset_busy (reset_busy),
		.i_sdo        (i_sdo)
	);

endmodule

// File: tb/dac_model.sv
`timescale 1ns/100ps

module dac_model (
	input  logic                     i_sclk,
	input  logic                     i_sync_n,
	input  logic                     i_sdin,
	input  logic                     i_fault,	// Corrupt stored code
	output logic                     o_sdo,
	output dac_ctrl_pkg::dac_frame_u o_wr_frame,	// Last write frame seen
	output int                       o_frame_cnt,
	output logic                     o_len_err	// Sticky, frame not 24 bits
);

	dac_ctrl_pkg::dac_frame_u            in_q;
	dac_ctrl_pkg::dac_frame_u            out_q;
	logic [dac_ctrl_pkg::DAC_CODE_W-1:0] ch_reg;	// Channel A register
	logic                                rd_pending;
	logic                                sync_q;
	int                                  bit_cnt;

	initial begin
		in_q        = '0;
		out_q       = '0;
		ch_reg      = '0;
		rd_pending  = 1'b0;
		sync_q      = 1'b1;
		bit_cnt     = 0;
		o_wr_frame  = '0;
		o_frame_cnt = 0;
		o_len_err   = 1'b0;
	end

	assign o_sdo = out_q.raw[dac_ctrl_pkg::FRAME_W-1];	// Held through sclk fall

	// ******************************
	// Frame start, shift, frame end
	// ******************************
	always @(negedge i_sclk or negedge i_sync_n or posedge i_sync_n) begin
		if (i_sync_n === 1'b0 && sync_q === 1'b1) begin
			bit_cnt = 0;
			out_q   = '0;
			if (rd_pending)
				out_q.fld.code = ch_reg;	// Readback in code field
			rd_pending = 1'b0;
		end else if (i_sync_n === 1'b1 && sync_q === 1'b0) begin
			if (bit_cnt != dac_ctrl_pkg::FRAME_W)
				o_len_err = 1'b1;
			if (in_q.fld.cmd == dac_ctrl_pkg::CMD_WRITE) begin
				ch_reg     = in_q.fld.code ^ {{(dac_ctrl_pkg::DAC_CODE_W-1){1'b0}}, i_fault};
				o_wr_frame = in_q;
			end
			if (in_q.fld.cmd == dac_ctrl_pkg::CMD_READ)
				rd_pending = 1'b1;
			o_frame_cnt = o_frame_cnt + 1;
		end else if (i_sync_n === 1'b0) begin	// sclk fall inside frame
			in_q.raw  = {in_q.raw[dac_ctrl_pkg::FRAME_W-2:0], i_sdin};
			out_q.raw = {out_q.raw[dac_ctrl_pkg::FRAME_W-2:0], 1'b0};
			bit_cnt   = bit_cnt + 1;
		end
		sync_q = i_sync_n;
	end

endmodule

// File: tb/dac_ctrl_sva.sv
`timescale 1ns/100ps

module dac_ctrl_sva (
	input logic sys_clk,
	input logic sys_rst,
	input logic i_awready,
	input logic i_bvalid,
	input logic i_bready,
	input logic i_dac_busy,
	input logic i_sync_n,
	input logic i_sdin,
	input logic i_reset_n
);

	// ******************************
	// Handshake rules
	// ******************************
	awready_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		i_awready |=> !i_awready) else $error("awready held longer than one cycle");

	awready_not_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
		i_awready |-> $past(!i_dac_busy)) else $error("address accepted while busy");

	bvalid_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		i_bvalid && !i_bready |=> i_bvalid) else $error("bvalid dropped without bready");

	// Serial frame rules
	sync_in_reset: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!i_reset_n |-> i_sync_n) else $error("frame during DAC reset");

	sdin_idle_low: assert property (@(posedge sys_clk) disable iff (sys_rst)
		i_sync_n |-> !i_sdin) else $error("sdin active outside a frame");

endmodule

bind dac_ctrl_top dac_ctrl_sva u_dac_ctrl_sva (
	.sys_clk    (sys_clk),
	.sys_rst    (sys_rst),
	.i_awready  (o_awready),
	.i_bvalid   (o_bvalid),
	.i_bready   (i_bready),
	.i_dac_busy (o_dac_busy),
	.i_sync_n   (o_sync_n),
	.i_sdin     (o_sdin),
	.i_reset_n  (o_reset_n)
);

// File: tb/tb_dac_ctrl_top.sv
`timescale 1ns/100ps

module tb_dac_ctrl_top;

	logic                                sys_clk;
	logic                                sys_rst;
	logic [dac_ctrl_pkg::AXI_ID_W-1:0]   awid;
	logic [dac_ctrl_pkg::AXI_LEN_W-1:0]  awlen;
	logic                                awvalid;
	logic                                awready;
	logic [dac_ctrl_pkg::AXI_DATA_W-1:0] wdata;
	logic                                wlast;
	logic                                wvalid;
	logic                                wready;
	logic [dac_ctrl_pkg::AXI_ID_W-1:0]   bid;
	logic [1:0]                          bresp;
	logic                                bvalid;
	logic                                bready;
	logic                                sclk;
	logic                                sync_n;
	logic                                sdin;
	logic                                reset_n;
	logic                                sdo;
	logic                                motor_state;
	logic                                motor_dir;
	logic                                dac_busy;
	logic                                dac_ok;
	logic                                fault;	// Model corrupts its register
	dac_ctrl_pkg::dac_frame_u            wr_frame;
	int                                  frame_cnt;
	logic                                len_err;

	logic [dac_ctrl_pkg::AXI_DATA_W-1:0] words [0:5];	// Beats of the next burst
	dac_ctrl_pkg::dac_frame_u            exp_frame;
	logic                                exp_ok;
	logic                                armed;	// Sequence result pending
	logic                                busy_q;
	int                                  checks_done;
	int                                  seq_count;

	initial sys_clk = 1'b0;
	always #10 sys_clk = ~sys_clk;

	dac_ctrl_top u_dac_ctrl_top (
		.sys_clk (sys_clk), .sys_rst (sys_rst),
		.i_awid (awid), .i_awlen (awlen), .i_awvalid (awvalid), .o_awready (awready),
		.i_wdata (wdata), .i_wlast (wlast), .i_wvalid (wvalid), .o_wready (wready),
		.o_bid (bid), .o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready),
		.o_sclk (sclk), .o_sync_n (sync_n), .o_sdin (sdin), .o_reset_n (reset_n),
		.i_sdo (sdo), .o_motor_state (motor_state), .o_motor_direction (motor_dir),
		.o_dac_busy (dac_busy), .o_dac_ok (dac_ok)
	);

	dac_model u_dac_model (
		.i_sclk (sclk), .i_sync_n (sync_n), .i_sdin (sdin), .i_fault (fault),
		.o_sdo (sdo), .o_wr_frame (wr_frame), .o_frame_cnt (frame_cnt), .o_len_err (len_err)
	);

	// ******************************
	// Reference and checks
	// ******************************
	function automatic dac_ctrl_pkg::dac_frame_u ref_frame(
		input  logic [dac_ctrl_pkg::DAC_CODE_W-1:0] code,
		input  logic                                corrupt,
		output logic                                ok
	);
		dac_ctrl_pkg::dac_frame_u fr;
		fr.raw = {4'd3, 4'd9, code, 6'd0};	// Write, all channels
		ok     = !corrupt;	// Readback differs only when corrupted
		return fr;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_frame(input string name, input dac_ctrl_pkg::dac_frame_u got,
		input dac_ctrl_pkg::dac_frame_u exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_id(input string name, input logic [dac_ctrl_pkg::AXI_ID_W-1:0] got,
		input logic [dac_ctrl_pkg::AXI_ID_W-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	// Result of each sequence at the fall of busy
	always @(posedge sys_clk) begin
		if (armed && busy_q && !dac_busy) begin
			check_bit("o_dac_ok", dac_ok, exp_ok);
			check_frame("write frame", wr_frame, exp_frame);
			if (len_err)
				stop_on_error("A serial frame did not have 24 sclk falls with sync_n low");
			if (frame_cnt != 3 * (checks_done + 1))	// Write, read, no-op per run
				stop_on_error($sformatf("FAILED %0t frame_cnt got %0d expected %0d",
					$time, frame_cnt, 3 * (checks_done + 1)));
			armed = 1'b0;
			checks_done = checks_done + 1;
		end
		busy_q <= dac_busy;
	end

	// Reset pulse length in sclk rises
	task automatic check_reset_pulse();
		int   rises;
		int   t;
		logic sclk_q;
		rises  = 0;
		t      = 0;
		sclk_q = 1'b0;
		while (!reset_n) begin
			@(posedge sys_clk);
			t++;
			if (t > 500)
				stop_on_error("Timeout waiting for the end of the DAC reset pulse");
			check_bit("o_sync_n", sync_n, 1'b1);
			if (awready || wready || bvalid)
				stop_on_error("AXI ready or valid active during the DAC reset pulse");
			if (!reset_n && sclk && !sclk_q)
				rises++;
			sclk_q = sclk;
		end
		if (rises != dac_ctrl_pkg::TIME_RESET)
			stop_on_error($sformatf("Reset pulse lasted %0d sclk rises", rises));
	endtask

	// ******************************
	// One burst, response and DAC run
	// ******************************
	task automatic run_burst(input logic [3:0] id, input int n, input int stall,
		input logic f, input logic wait_done);
		int   t;
		int   b;
		logic exp_state;
		logic exp_dir;
		logic busy_s;
		exp_state = (words[0] == dac_ctrl_pkg::MOTOR_ENABLE);
		exp_dir   = (words[1] == dac_ctrl_pkg::MOTOR_POSITIVE);
		fault   <= f;
		awid    <= id;
		awlen   <= 8'(n - 1);
		awvalid <= 1'b1;
		t = 0;
		busy_s = 1'b0;
		do begin	// Address phase
			@(posedge sys_clk);
			t++;
			if (awready && busy_s)
				stop_on_error("Address accepted while the DAC was busy");
			busy_s = dac_busy;
			if (t > 5000)
				stop_on_error("Timeout waiting for o_awready");
		end while (!awready);
		awvalid <= 1'b0;
		exp_frame = ref_frame(words[2][dac_ctrl_pkg::DAC_CODE_W-1:0], f, exp_ok);
		armed = 1'b1;
		seq_count++;
		b = 0;
		t = 0;
		wvalid <= 1'b1;
		wdata  <= words[0];
		wlast  <= (n == 1);
		while (b < n) begin
			@(posedge sys_clk);
			t++;
			if (t > 200)
				stop_on_error("Timeout waiting for o_wready");
			if (wready) begin	// Beat taken
				b++;
				if (b < n) begin
					wdata <= words[b];
					wlast <= (b == n - 1);
				end else begin
					wvalid <= 1'b0;
					wlast  <= 1'b0;
				end
			end
		end
		t = 0;
		do begin
			@(posedge sys_clk);
			t++;
			if (t > 50)
				stop_on_error("Timeout waiting for o_bvalid");
		end while (!bvalid);
		repeat (stall) begin	// bready held low
			@(posedge sys_clk);
			check_bit("o_bvalid", bvalid, 1'b1);
		end
		bready <= 1'b1;
		@(posedge sys_clk);
		check_bit("o_bvalid", bvalid, 1'b1);
		check_id("o_bid", bid, id);
		check_resp("o_bresp", bresp, dac_ctrl_pkg::BRESP_OKAY);
		bready <= 1'b0;
		check_bit("o_motor_state", motor_state, exp_state);
		check_bit("o_motor_direction", motor_dir, exp_dir);
		if (wait_done) begin
			t = 0;
			while (armed) begin
				@(posedge sys_clk);
				t++;
				if (t > 5000)
					stop_on_error("Timeout waiting for the DAC sequence to finish");
			end
		end
	endtask

	task automatic fill_words();
		for (int i = 0; i < 6; i++)
			words[i] = {$urandom, $urandom};
		if ($urandom_range(0, 1))
			words[0] = dac_ctrl_pkg::MOTOR_ENABLE;
		if ($urandom_range(0, 1))
			words[1] = dac_ctrl_pkg::MOTOR_POSITIVE;
	endtask

	initial begin
		int t;
		void'($urandom(8));
		sys_rst = 1'b1;
		awid = '0;
		awlen = '0;
		awvalid = 1'b0;
		wdata = '0;
		wlast = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		fault = 1'b0;
		armed = 1'b0;
		busy_q = 1'b0;
		checks_done = 0;
		seq_count = 0;
		repeat (4) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(posedge sys_clk);
		check_reset_pulse();
		for (int i = 0; i < 6; i++) begin
			fill_words();
			run_burst(4'($urandom), 3 + int'($urandom_range(0, 3)), (i == 2) ? 4 : 0,
				(i == 3), 1'b1);
		end
		// Second address lands while the first sequence runs
		fill_words();
		run_burst(4'($urandom), 4, 0, 1'b0, 1'b0);
		fill_words();
		run_burst(4'($urandom), 3, 2, 1'b0, 1'b1);
		t = 0;
		while (dac_busy) begin
			@(posedge sys_clk);
			t++;
			if (t > 5000)
				stop_on_error("Timeout waiting for o_dac_busy to fall");
		end
		if (checks_done != seq_count)
			stop_on_error("A DAC sequence ended without a checked result");
		else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

// File: dac_ctrl_top.f
design/dac_ctrl_pkg.sv
design/axi_write_slave.sv
design/motor_cmd_decode.sv
design/dac_serial_engine.sv
design/dac_sequencer.sv
design/dac_ctrl_top.sv
tb/dac_model.sv
tb/dac_ctrl_sva.sv
tb/tb_dac_ctrl_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_dac_ctrl_top \
		-f dac_ctrl_top.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
